//--- pms_defines.svh
`ifndef PMS_DEFINES_SVH
`define PMS_DEFINES_SVH

`define PMS_WORD_W      32
`define PMS_EXC_W       5
`define PMS_LS_W        7

// data cache address split
`define PMS_TAG_W       20
`define PMS_INDEX_W     8
`define PMS_OFFSET_W    4

`define PMS_EXC_ADEL    5'h04   // load or fetch address error
`define PMS_EXC_ADES    5'h05   // store address error

`define PMS_VEC_REFILL  32'hbfc0_0200
`define PMS_VEC_GENERAL 32'hbfc0_0380

// one-hot access kind bits
`define LS_B            6
`define LS_BU           5
`define LS_H            4
`define LS_HU           3
`define LS_W            2
`define LS_L            1
`define LS_R            0

`endif

//--- pms_mem_pkg.sv
`include "pms_defines.svh"

package pms_mem_pkg;

    // one-hot, see LS_* bit positions
    typedef logic [`PMS_LS_W-1:0] ls_type_t;

    typedef logic [3:0] strb_t;     // byte lane write mask

    // 0 byte, 1 half, 2 word
    typedef logic [1:0] size_t;

    typedef logic [`PMS_TAG_W-1:0]    tag_t;
    typedef logic [`PMS_INDEX_W-1:0]  index_t;
    typedef logic [`PMS_OFFSET_W-1:0] offset_t;

endpackage

//--- pms_exc_pkg.sv
`include "pms_defines.svh"

package pms_exc_pkg;

    typedef logic [`PMS_WORD_W-1:0] word_t;    // address or data word

    // mips cause register code
    typedef logic [`PMS_EXC_W-1:0] exccode_t;

endpackage

//--- mem_access_decode.sv
`timescale 1ns/1ns
`include "pms_defines.svh"

module mem_access_decode
    import pms_mem_pkg::*;
    import pms_exc_pkg::*;
(
    input  ls_type_t ls_type,
    input  word_t    mem_addr,
    input  word_t    rt_value,
    input  logic     load_op,
    input  logic     mem_we,
    output word_t    va,
    output tag_t     tag,
    output index_t   index,
    output offset_t  offset,
    output logic     uncache,
    output size_t    size,
    output strb_t    wstrb_raw,
    output word_t    wdata,
    output logic     ade_load,
    output logic     ade_store
);

    logic [1:0] lane;
    logic       misalign;
    word_t      pa;

    assign lane = mem_addr[1:0];

    // left accesses go out word aligned
    assign va      = ls_type[`LS_L] ? {mem_addr[31:2], 2'b00} : mem_addr;
    assign pa      = {3'b000, va[28:0]};    // fixed kseg mapping
    assign tag     = pa[31:12];
    assign index   = pa[11:4];
    assign offset  = pa[3:0];
    assign uncache = (va[31:29] == 3'b101); // kseg1

    always_comb begin
        size = 2'd0;
        if (ls_type[`LS_H] || ls_type[`LS_HU]) begin
            size = 2'd1;
        end else if (ls_type[`LS_W]) begin
            size = 2'd2;
        end else if (ls_type[`LS_L]) begin
            size = (lane == 2'd0) ? 2'd0 : (lane == 2'd1) ? 2'd1 : 2'd2;
        end else if (ls_type[`LS_R]) begin
            size = (lane == 2'd3) ? 2'd0 : (lane == 2'd2) ? 2'd1 : 2'd2;
        end
    end

    always_comb begin
        wstrb_raw = 4'b0000;
        wdata     = '0;
        if (ls_type[`LS_B]) begin
            wstrb_raw = 4'b0001 << lane;
            wdata     = {4{rt_value[7:0]}};
        end else if (ls_type[`LS_H]) begin
            wstrb_raw = lane[1] ? 4'b1100 : 4'b0011;
            wdata     = {2{rt_value[15:0]}};
        end else if (ls_type[`LS_W]) begin
            wstrb_raw = 4'b1111;
            wdata     = rt_value;
        end else if (ls_type[`LS_L]) begin
            // high bytes of rt land in lanes 0..lane
            wstrb_raw = 4'b1111 >> (2'd3 - lane);
            wdata     = rt_value >> {2'd3 - lane, 3'b000};
        end else if (ls_type[`LS_R]) begin
            wstrb_raw = 4'b1111 << lane;            // lanes lane..3
            wdata     = rt_value << {lane, 3'b000};
        end
    end

    assign misalign  = ((ls_type[`LS_H] || ls_type[`LS_HU]) && lane[0])
                    || (ls_type[`LS_W] && (lane != 2'b00));
    assign ade_load  = load_op && misalign;
    assign ade_store = mem_we && misalign;

endmodule

//--- exception_select.sv
`timescale 1ns/1ns
`include "pms_defines.svh"

module exception_select
    import pms_exc_pkg::*;
(
    input  logic     pms_valid,
    input  logic     inst1_es_except, inst1_ade_load, inst1_ade_store,
    input  logic     inst1_refill, inst1_eret, inst1_bd,
    input  exccode_t inst1_es_exccode,
    input  word_t    inst1_pc, inst1_va,
    input  logic     inst2_es_except, inst2_ade_load, inst2_ade_store,
    input  logic     inst2_refill, inst2_eret, inst2_bd,
    input  exccode_t inst2_es_exccode,
    input  word_t    inst2_pc, inst2_va,
    output logic     inst1_pms_except,
    output logic     inst2_pms_except,
    output logic     pms_ex,
    output exccode_t ex_type,
    output logic     pms_bd,
    output word_t    pms_pc,
    output word_t    pms_badvaddr,
    output logic     pms_eret,
    output logic     clear_all,
    output word_t    reflush_pc
);

    exccode_t inst1_exccode;
    exccode_t inst2_exccode;
    logic     win_refill;

    assign inst1_pms_except = pms_valid && (inst1_es_except || inst1_ade_load || inst1_ade_store);
    assign inst2_pms_except = pms_valid && (inst2_es_except || inst2_ade_load || inst2_ade_store);

    // execute fault first, then load, then store
    assign inst1_exccode = inst1_es_except ? inst1_es_exccode :
                           inst1_ade_load  ? `PMS_EXC_ADEL : `PMS_EXC_ADES;
    assign inst2_exccode = inst2_es_except ? inst2_es_exccode :
                           inst2_ade_load  ? `PMS_EXC_ADEL : `PMS_EXC_ADES;

    assign pms_ex = inst1_pms_except || inst2_pms_except;

    always_comb begin
        ex_type      = '0;
        pms_bd       = 1'b0;
        pms_pc       = '0;
        pms_badvaddr = '0;
        win_refill   = 1'b0;
        if (inst1_pms_except) begin         // older slot wins
            ex_type      = inst1_exccode;
            pms_bd       = inst1_bd;
            pms_pc       = inst1_pc;
            pms_badvaddr = inst1_va;
            win_refill   = inst1_refill;
        end else if (inst2_pms_except) begin
            ex_type      = inst2_exccode;
            pms_bd       = inst2_bd;
            pms_pc       = inst2_pc;
            pms_badvaddr = inst2_va;
            win_refill   = inst2_refill;
        end
    end

    assign pms_eret   = pms_valid && (inst1_eret || inst2_eret);
    assign clear_all  = pms_ex || pms_eret;
    assign reflush_pc = !pms_ex    ? '0 :
                        win_refill ? `PMS_VEC_REFILL : `PMS_VEC_GENERAL;

endmodule

//--- pms_pipe_ctrl.sv
`timescale 1ns/1ns

module pms_pipe_ctrl
    import pms_mem_pkg::*;
    import pms_exc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     es_to_pms_valid,
    input  logic     ms_allowin,
    input  logic     inst1_load_op, inst1_mem_we, inst1_bd, inst1_refill, inst1_eret,
    input  logic     inst1_es_except, inst1_data_cache_addr_ok, inst1_pms_except,
    input  ls_type_t inst1_ls_type,
    input  word_t    inst1_mem_addr, inst1_rt_value, inst1_pc,
    input  exccode_t inst1_es_exccode,
    input  strb_t    inst1_wstrb_raw,
    input  logic     inst2_load_op, inst2_mem_we, inst2_bd, inst2_refill, inst2_eret,
    input  logic     inst2_es_except, inst2_data_cache_addr_ok, inst2_pms_except,
    input  ls_type_t inst2_ls_type,
    input  word_t    inst2_mem_addr, inst2_rt_value, inst2_pc,
    input  exccode_t inst2_es_exccode,
    input  strb_t    inst2_wstrb_raw,
    input  logic     clear_all,
    output logic     pms_valid,
    output logic     pms_allowin,
    output logic     pms_to_ms_valid,
    output logic     pms_inst2_valid,
    output logic     inst1_load_op_r, inst1_mem_we_r, inst1_bd_r, inst1_refill_r, inst1_eret_r,
    output logic     inst1_es_except_r,
    output ls_type_t inst1_ls_type_r,
    output word_t    inst1_mem_addr_r, inst1_rt_value_r, inst1_pc_r,
    output exccode_t inst1_es_exccode_r,
    output logic     inst2_load_op_r, inst2_mem_we_r, inst2_bd_r, inst2_refill_r, inst2_eret_r,
    output logic     inst2_es_except_r,
    output ls_type_t inst2_ls_type_r,
    output word_t    inst2_mem_addr_r, inst2_rt_value_r, inst2_pc_r,
    output exccode_t inst2_es_exccode_r,
    output logic     inst1_data_cache_valid, inst1_data_cache_op,
    output strb_t    inst1_data_cache_wstrb,
    output logic     inst2_data_cache_valid, inst2_data_cache_op,
    output strb_t    inst2_data_cache_wstrb
);

    logic inst1_addr_ok_r, inst2_addr_ok_r;
    logic inst1_access, inst2_access;
    logic inst1_accept, inst2_accept;
    logic inst1_ready_go, inst2_ready_go;
    logic pms_ready_go;
    logic handoff;

    assign inst1_access = inst1_load_op_r || inst1_mem_we_r;
    assign inst2_access = inst2_load_op_r || inst2_mem_we_r;

    // slot 2 stays quiet behind a slot 1 fault
    assign inst1_data_cache_valid = inst1_access && pms_valid && ms_allowin
                                 && !inst1_pms_except && !inst1_addr_ok_r;
    assign inst2_data_cache_valid = inst2_access && pms_valid && ms_allowin
                                 && !inst1_pms_except && !inst2_pms_except && !inst2_addr_ok_r;
    assign inst1_data_cache_op = inst1_mem_we_r && pms_valid && !inst1_pms_except;
    assign inst2_data_cache_op = inst2_mem_we_r && pms_valid
                              && !inst1_pms_except && !inst2_pms_except;
    assign inst1_data_cache_wstrb = inst1_data_cache_op ? inst1_wstrb_raw : 4'b0000;
    assign inst2_data_cache_wstrb = inst2_data_cache_op ? inst2_wstrb_raw : 4'b0000;

    assign inst1_accept = inst1_data_cache_valid && inst1_data_cache_addr_ok;
    assign inst2_accept = inst2_data_cache_valid && inst2_data_cache_addr_ok;

    assign inst1_ready_go = !inst1_access || inst1_accept || inst1_addr_ok_r || inst1_pms_except;
    assign inst2_ready_go = !inst2_access || inst2_accept || inst2_addr_ok_r || inst2_pms_except;

    assign pms_ready_go    = (inst1_ready_go && inst2_ready_go) || clear_all;
    assign pms_allowin     = !pms_valid || (pms_ready_go && ms_allowin);
    assign pms_to_ms_valid = pms_valid && pms_ready_go;
    assign pms_inst2_valid = pms_valid && !inst2_pms_except;
    assign handoff         = pms_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            pms_valid       <= 1'b0;
            inst1_addr_ok_r <= 1'b0;
            inst2_addr_ok_r <= 1'b0;
        end else begin
            if (inst1_pms_except) begin
                pms_valid <= 1'b0;      // flushed with the younger slot
            end else if (pms_allowin) begin
                pms_valid <= es_to_pms_valid;
            end
            if (handoff) begin
                inst1_addr_ok_r <= 1'b0;
            end else if (inst1_accept) begin
                inst1_addr_ok_r <= 1'b1;
            end
            if (handoff) begin
                inst2_addr_ok_r <= 1'b0;
            end else if (inst2_accept) begin
                inst2_addr_ok_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_pms_valid && pms_allowin) begin
            inst1_load_op_r    <= inst1_load_op;
            inst1_mem_we_r     <= inst1_mem_we;
            inst1_bd_r         <= inst1_bd;
            inst1_refill_r     <= inst1_refill;
            inst1_eret_r       <= inst1_eret;
            inst1_es_except_r  <= inst1_es_except;
            inst1_ls_type_r    <= inst1_ls_type;
            inst1_mem_addr_r   <= inst1_mem_addr;
            inst1_rt_value_r   <= inst1_rt_value;
            inst1_pc_r         <= inst1_pc;
            inst1_es_exccode_r <= inst1_es_exccode;
            inst2_load_op_r    <= inst2_load_op;
            inst2_mem_we_r     <= inst2_mem_we;
            inst2_bd_r         <= inst2_bd;
            inst2_refill_r     <= inst2_refill;
            inst2_eret_r       <= inst2_eret;
            inst2_es_except_r  <= inst2_es_except;
            inst2_ls_type_r    <= inst2_ls_type;
            inst2_mem_addr_r   <= inst2_mem_addr;
            inst2_rt_value_r   <= inst2_rt_value;
            inst2_pc_r         <= inst2_pc;
            inst2_es_exccode_r <= inst2_es_exccode;
        end
    end

endmodule

//--- premem_stage.sv
`timescale 1ns/1ns

module premem_stage
    import pms_mem_pkg::*;
    import pms_exc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     es_to_pms_valid,
    input  logic     ms_allowin,
    // from execute
    input  logic     inst1_load_op, inst1_mem_we, inst1_bd, inst1_refill, inst1_eret,
    input  logic     inst1_es_except,
    input  ls_type_t inst1_ls_type,
    input  word_t    inst1_mem_addr, inst1_rt_value, inst1_pc,
    input  exccode_t inst1_es_exccode,
    input  logic     inst2_load_op, inst2_mem_we, inst2_bd, inst2_refill, inst2_eret,
    input  logic     inst2_es_except,
    input  ls_type_t inst2_ls_type,
    input  word_t    inst2_mem_addr, inst2_rt_value, inst2_pc,
    input  exccode_t inst2_es_exccode,
    // data cache
    output logic     inst1_data_cache_valid, inst1_data_cache_op, inst1_data_cache_uncache,
    output tag_t     inst1_data_cache_tag,
    output index_t   inst1_data_cache_index,
    output offset_t  inst1_data_cache_offset,
    output size_t    inst1_data_cache_size,
    output strb_t    inst1_data_cache_wstrb,
    output word_t    inst1_data_cache_wdata,
    input  logic     inst1_data_cache_addr_ok,
    output logic     inst2_data_cache_valid, inst2_data_cache_op, inst2_data_cache_uncache,
    output tag_t     inst2_data_cache_tag,
    output index_t   inst2_data_cache_index,
    output offset_t  inst2_data_cache_offset,
    output size_t    inst2_data_cache_size,
    output strb_t    inst2_data_cache_wstrb,
    output word_t    inst2_data_cache_wdata,
    input  logic     inst2_data_cache_addr_ok,
    output logic     pms_allowin, pms_to_ms_valid, pms_inst2_valid, clear_all,
    output word_t    reflush_pc,
    // exception report
    output logic     pms_ex, pms_bd, pms_eret,
    output exccode_t ex_type,
    output word_t    pms_pc, pms_badvaddr
);

    logic     pms_valid;
    logic     inst1_load_op_r, inst1_mem_we_r, inst1_bd_r, inst1_refill_r, inst1_eret_r;
    logic     inst1_es_except_r, inst1_ade_load, inst1_ade_store, inst1_pms_except;
    ls_type_t inst1_ls_type_r;
    word_t    inst1_mem_addr_r, inst1_rt_value_r, inst1_pc_r, inst1_va;
    exccode_t inst1_es_exccode_r;
    strb_t    inst1_wstrb_raw;
    logic     inst2_load_op_r, inst2_mem_we_r, inst2_bd_r, inst2_refill_r, inst2_eret_r;
    logic     inst2_es_except_r, inst2_ade_load, inst2_ade_store, inst2_pms_except;
    ls_type_t inst2_ls_type_r;
    word_t    inst2_mem_addr_r, inst2_rt_value_r, inst2_pc_r, inst2_va;
    exccode_t inst2_es_exccode_r;
    strb_t    inst2_wstrb_raw;

    pms_pipe_ctrl ctrl_i (.*);    // port names match the stage signals

    mem_access_decode dec1_i (
        .ls_type   (inst1_ls_type_r),
        .mem_addr  (inst1_mem_addr_r),
        .rt_value  (inst1_rt_value_r),
        .load_op   (inst1_load_op_r),
        .mem_we    (inst1_mem_we_r),
        .va        (inst1_va),
        .tag       (inst1_data_cache_tag),
        .index     (inst1_data_cache_index),
        .offset    (inst1_data_cache_offset),
        .uncache   (inst1_data_cache_uncache),
        .size      (inst1_data_cache_size),
        .wstrb_raw (inst1_wstrb_raw),
        .wdata     (inst1_data_cache_wdata),
        .ade_load  (inst1_ade_load),
        .ade_store (inst1_ade_store)
    );

    mem_access_decode dec2_i (
        .ls_type   (inst2_ls_type_r),
        .mem_addr  (inst2_mem_addr_r),
        .rt_value  (inst2_rt_value_r),
        .load_op   (inst2_load_op_r),
        .mem_we    (inst2_mem_we_r),
        .va        (inst2_va),
        .tag       (inst2_data_cache_tag),
        .index     (inst2_data_cache_index),
        .offset    (inst2_data_cache_offset),
        .uncache   (inst2_data_cache_uncache),
        .size      (inst2_data_cache_size),
        .wstrb_raw (inst2_wstrb_raw),
        .wdata     (inst2_data_cache_wdata),
        .ade_load  (inst2_ade_load),
        .ade_store (inst2_ade_store)
    );

    exception_select exc_i (
        .pms_valid        (pms_valid),
        .inst1_es_except  (inst1_es_except_r),
        .inst1_ade_load   (inst1_ade_load),
        .inst1_ade_store  (inst1_ade_store),
        .inst1_refill     (inst1_refill_r),
        .inst1_eret       (inst1_eret_r),
        .inst1_bd         (inst1_bd_r),
        .inst1_es_exccode (inst1_es_exccode_r),
        .inst1_pc         (inst1_pc_r),
        .inst1_va         (inst1_va),
        .inst2_es_except  (inst2_es_except_r),
        .inst2_ade_load   (inst2_ade_load),
        .inst2_ade_store  (inst2_ade_store),
        .inst2_refill     (inst2_refill_r),
        .inst2_eret       (inst2_eret_r),
        .inst2_bd         (inst2_bd_r),
        .inst2_es_exccode (inst2_es_exccode_r),
        .inst2_pc         (inst2_pc_r),
        .inst2_va         (inst2_va),
        .inst1_pms_except (inst1_pms_except),
        .inst2_pms_except (inst2_pms_except),
        .pms_ex           (pms_ex),
        .ex_type          (ex_type),
        .pms_bd           (pms_bd),
        .pms_pc           (pms_pc),
        .pms_badvaddr     (pms_badvaddr),
        .pms_eret         (pms_eret),
        .clear_all        (clear_all),
        .reflush_pc       (reflush_pc)
    );

endmodule

//--- premem_checker.sv
`timescale 1ns/1ns

module premem_checker
    import pms_mem_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  pms_valid,
    input logic  clear_all,
    input logic  pms_to_ms_valid,
    input logic  inst1_pms_except,
    input logic  inst2_pms_except,
    input logic  inst1_data_cache_valid,
    input logic  inst1_data_cache_op,
    input strb_t inst1_data_cache_wstrb,
    input logic  inst1_data_cache_addr_ok,
    input logic  inst2_data_cache_valid,
    input logic  inst2_data_cache_op,
    input strb_t inst2_data_cache_wstrb,
    input logic  inst2_data_cache_addr_ok
);

    int fail_count = 0;     // failed assertions

    // every store lane table strobes at least one byte
    strb_op_1: assert property (@(posedge clk) disable iff (reset)
        (inst1_data_cache_wstrb != 4'b0000) == inst1_data_cache_op)
        else begin
            $error("slot 1 strobe and store op disagree");
            fail_count++;
        end
    strb_op_2: assert property (@(posedge clk) disable iff (reset)
        (inst2_data_cache_wstrb != 4'b0000) == inst2_data_cache_op)
        else begin
            $error("slot 2 strobe and store op disagree");
            fail_count++;
        end
    no_req_on_fault_1: assert property (@(posedge clk) disable iff (reset)
        inst1_pms_except |-> !inst1_data_cache_valid)
        else begin
            $error("slot 1 request on a faulting slot");
            fail_count++;
        end
    no_req_on_fault_2: assert property (@(posedge clk) disable iff (reset)
        (inst1_pms_except || inst2_pms_except) |-> !inst2_data_cache_valid)
        else begin
            $error("slot 2 request behind a fault");
            fail_count++;
        end
    clear_needs_valid: assert property (@(posedge clk) disable iff (reset)
        clear_all |-> pms_valid)
        else begin
            $error("clear_all on an empty stage");
            fail_count++;
        end
    // no pending request left behind on a normal handoff
    to_ms_needs_valid: assert property (@(posedge clk) disable iff (reset)
        pms_to_ms_valid |-> pms_valid && (clear_all
            || ((!inst1_data_cache_valid || inst1_data_cache_addr_ok)
            && (!inst2_data_cache_valid || inst2_data_cache_addr_ok))))
        else begin
            $error("pms_to_ms_valid on an empty or waiting stage");
            fail_count++;
        end

endmodule

bind premem_stage premem_checker chk_i (
    .clk                      (clk),
    .reset                    (reset),
    .pms_valid                (pms_valid),
    .clear_all                (clear_all),
    .pms_to_ms_valid          (pms_to_ms_valid),
    .inst1_pms_except         (inst1_pms_except),
    .inst2_pms_except         (inst2_pms_except),
    .inst1_data_cache_valid   (inst1_data_cache_valid),
    .inst1_data_cache_op      (inst1_data_cache_op),
    .inst1_data_cache_wstrb   (inst1_data_cache_wstrb),
    .inst1_data_cache_addr_ok (inst1_data_cache_addr_ok),
    .inst2_data_cache_valid   (inst2_data_cache_valid),
    .inst2_data_cache_op      (inst2_data_cache_op),
    .inst2_data_cache_wstrb   (inst2_data_cache_wstrb),
    .inst2_data_cache_addr_ok (inst2_data_cache_addr_ok)
);

//--- tb_premem_stage.sv
`timescale 1ns/1ns
`include "pms_defines.svh"

module tb_premem_stage
    import pms_mem_pkg::*;
    import pms_exc_pkg::*;
;
    logic clk = 1'b0, reset = 1'b1, es_to_pms_valid, ms_allowin;
    logic inst1_load_op, inst1_mem_we, inst1_bd, inst1_refill, inst1_eret, inst1_es_except;
    logic inst2_load_op, inst2_mem_we, inst2_bd, inst2_refill, inst2_eret, inst2_es_except;
    ls_type_t inst1_ls_type, inst2_ls_type;
    word_t inst1_mem_addr, inst1_rt_value, inst1_pc, inst2_mem_addr, inst2_rt_value, inst2_pc;
    exccode_t inst1_es_exccode, inst2_es_exccode, ex_type;
    logic inst1_data_cache_valid, inst1_data_cache_op, inst1_data_cache_uncache;
    logic inst2_data_cache_valid, inst2_data_cache_op, inst2_data_cache_uncache;
    tag_t inst1_data_cache_tag, inst2_data_cache_tag;
    index_t inst1_data_cache_index, inst2_data_cache_index;
    offset_t inst1_data_cache_offset, inst2_data_cache_offset;
    size_t inst1_data_cache_size, inst2_data_cache_size;
    strb_t inst1_data_cache_wstrb, inst2_data_cache_wstrb;
    word_t inst1_data_cache_wdata, inst2_data_cache_wdata;
    logic inst1_data_cache_addr_ok, inst2_data_cache_addr_ok;
    logic pms_allowin, pms_to_ms_valid, pms_inst2_valid, clear_all, pms_ex, pms_bd, pms_eret;
    word_t reflush_pc, pms_pc, pms_badvaddr;

    string cur_test;
    int test_errs, tests_run, tests_failed, cycles;
    ls_type_t s_ls[1:2];
    word_t s_addr[1:2], s_rt[1:2];
    logic s_we[1:2];

    premem_stage dut_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > 6 * 200) begin
            $display("run stopped, cycle limit reached in test %s", cur_test);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic strb_t lane_mask(ls_type_t ls, logic [1:0] lane);
        if (ls[`LS_B]) return strb_t'(1) << lane;
        if (ls[`LS_H]) return lane[1] ? 4'b1100 : 4'b0011;
        if (ls[`LS_W]) return 4'b1111;
        if (ls[`LS_L]) return {lane == 2'd3, lane >= 2'd2, lane >= 2'd1, 1'b1};
        if (ls[`LS_R]) return {1'b1, lane <= 2'd2, lane <= 2'd1, lane == 2'd0};
        return 4'b0000;
    endfunction

    function automatic word_t store_data(ls_type_t ls, logic [1:0] lane, word_t rt);
        if (ls[`LS_B]) return {4{rt[7:0]}};
        if (ls[`LS_H]) return {2{rt[15:0]}};
        if (ls[`LS_L]) begin
            case (lane)
                2'd0: return {24'b0, rt[31:24]};
                2'd1: return {16'b0, rt[31:16]};
                2'd2: return {8'b0, rt[31:8]};
                default: return rt;
            endcase
        end
        if (ls[`LS_R]) begin
            case (lane)
                2'd0: return rt;
                2'd1: return {rt[23:0], 8'b0};
                2'd2: return {rt[15:0], 16'b0};
                default: return {rt[7:0], 24'b0};
            endcase
        end
        return rt;  // word store
    endfunction

    function automatic size_t access_size(ls_type_t ls, logic [1:0] lane);
        int nbytes;
        nbytes = 1;
        if (ls[`LS_H] || ls[`LS_HU]) nbytes = 2;
        if (ls[`LS_W]) nbytes = 4;
        if (ls[`LS_L]) nbytes = int'(lane) + 1;    // lanes 0..lane
        if (ls[`LS_R]) nbytes = 4 - int'(lane);    // lanes lane..3
        case (nbytes)
            1: return 2'd0;
            2: return 2'd1;
            default: return 2'd2;   // three bytes go out as a word
        endcase
    endfunction

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic set_slot(int n, ls_type_t ls, logic ld, logic we, word_t addr, word_t rt,
                            word_t pc, logic exc, exccode_t code, logic refill);
        s_ls[n] = ls;
        s_addr[n] = addr;
        s_rt[n] = rt;
        s_we[n] = we;
        if (n == 1) begin
            inst1_ls_type = ls;
            inst1_load_op = ld;
            inst1_mem_we = we;
            inst1_mem_addr = addr;
            inst1_rt_value = rt;
            inst1_pc = pc;
            inst1_es_except = exc;
            inst1_es_exccode = code;
            inst1_refill = refill;
            inst1_bd = 1'b0;
            inst1_eret = 1'b0;
        end else begin
            inst2_ls_type = ls;
            inst2_load_op = ld;
            inst2_mem_we = we;
            inst2_mem_addr = addr;
            inst2_rt_value = rt;
            inst2_pc = pc;
            inst2_es_except = exc;
            inst2_es_exccode = code;
            inst2_refill = refill;
            inst2_bd = 1'b0;
            inst2_eret = 1'b0;
        end
    endtask

    // caller sets the fields 1 ns after an edge
    task automatic capture();
        es_to_pms_valid = 1'b1;
        #2 check("allowin before capture", 1, pms_allowin);
        @(posedge clk);
        #1 es_to_pms_valid = 1'b0;
    endtask

    task automatic compare_request(int n);
        word_t va;
        logic [1:0] lane;
        logic v, op, unc;
        strb_t st;
        size_t sz;
        word_t wd;
        logic [31:0] pa_bits;
        lane = s_addr[n][1:0];
        va = s_ls[n][`LS_L] ? {s_addr[n][31:2], 2'b00} : s_addr[n];
        if (n == 1) begin
            v = inst1_data_cache_valid;
            op = inst1_data_cache_op;
            unc = inst1_data_cache_uncache;
            st = inst1_data_cache_wstrb;
            sz = inst1_data_cache_size;
            wd = inst1_data_cache_wdata;
            pa_bits = {inst1_data_cache_tag, inst1_data_cache_index, inst1_data_cache_offset};
        end else begin
            v = inst2_data_cache_valid;
            op = inst2_data_cache_op;
            unc = inst2_data_cache_uncache;
            st = inst2_data_cache_wstrb;
            sz = inst2_data_cache_size;
            wd = inst2_data_cache_wdata;
            pa_bits = {inst2_data_cache_tag, inst2_data_cache_index, inst2_data_cache_offset};
        end
        check($sformatf("slot%0d valid", n), 1, v);
        check($sformatf("slot%0d op", n), s_we[n], op);
        check($sformatf("slot%0d wstrb", n), s_we[n] ? lane_mask(s_ls[n], lane) : 4'b0, st);
        if (s_we[n]) begin
            check($sformatf("slot%0d wdata", n), store_data(s_ls[n], lane, s_rt[n]), wd);
        end
        check($sformatf("slot%0d size", n), access_size(s_ls[n], lane), sz);
        check($sformatf("slot%0d paddr", n), {3'b000, va[28:0]}, pa_bits);
        check($sformatf("slot%0d uncache", n), va[31:29] == 3'b101, unc);
    endtask

    task automatic random_slot(int n);
        int k;
        logic st;
        logic [1:0] lane;
        ls_type_t ls;
        k = $urandom_range(0, 6);
        ls = '0;
        ls[k] = 1'b1;
        st = (k != `LS_BU) && (k != `LS_HU) && ($urandom_range(0, 1) == 1);
        lane = 2'($urandom_range(0, 3));
        if (ls[`LS_H] || ls[`LS_HU]) lane[0] = 1'b0;
        if (ls[`LS_W]) lane = 2'b00;
        set_slot(n, ls, !st, st, {30'($urandom()), lane}, $urandom(), $urandom(), 0, 0, 0);
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %s: %s (%0d failed checks)", cur_test, test_errs ? "FAIL" : "pass",
                 test_errs);
    endtask

    initial begin
        int chk_fails;
        void'($urandom(32'h72f16baf));
        es_to_pms_valid = 0;
        ms_allowin = 1;
        inst1_data_cache_addr_ok = 0;
        inst2_data_cache_addr_ok = 0;
        set_slot(1, '0, 0, 0, 0, 0, 0, 0, 0, 0);
        set_slot(2, '0, 0, 0, 0, 0, 0, 0, 0, 0);
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        begin_test("reset");
        #2 check("valid1", 0, inst1_data_cache_valid);
        check("valid2", 0, inst2_data_cache_valid);
        check("to_ms", 0, pms_to_ms_valid);
        check("clear_all", 0, clear_all);
        check("pms_ex", 0, pms_ex);
        check("allowin", 1, pms_allowin);
        @(posedge clk);
        #1 end_test();

        begin_test("aligned_access");
        repeat (40) begin
            random_slot(1);
            random_slot(2);
            capture();
            inst1_data_cache_addr_ok = 1;
            inst2_data_cache_addr_ok = 1;
            #2 compare_request(1);
            compare_request(2);
            check("to_ms", 1, pms_to_ms_valid);
            check("inst2_valid", 1, pms_inst2_valid);
            @(posedge clk);
            #1 inst1_data_cache_addr_ok = 0;
            inst2_data_cache_addr_ok = 0;
        end
        end_test();

        begin_test("misaligned_slot1");
        repeat (8) begin
            logic st, half;
            word_t a;
            st = $urandom_range(0, 1) == 1;
            half = $urandom_range(0, 1) == 1;
            a = {30'($urandom()), half ? 2'b01 : 2'($urandom_range(1, 3))};
            if ($urandom_range(0, 1) == 1 && half) a[1] = 1'b1;
            set_slot(1, half ? 7'b001_0000 : 7'b000_0100, !st, st, a, $urandom(), 32'h100,
                     0, 0, 0);
            set_slot(2, 7'b000_0100, 1, 0, {30'($urandom()), 2'b00}, 0, 32'h104, 0, 0, 0);
            capture();
            #2 check("pms_ex", 1, pms_ex);
            check("clear_all", 1, clear_all);
            check("ex_type", st ? 5 : 4, ex_type);
            check("badvaddr", a, pms_badvaddr);
            check("reflush_pc", `PMS_VEC_GENERAL, reflush_pc);
            check("valid1", 0, inst1_data_cache_valid);
            check("valid2", 0, inst2_data_cache_valid);
            @(posedge clk);
            #1;
        end
        end_test();

        begin_test("refill_slot2");
        set_slot(1, 7'b000_0100, 1, 0, 32'h8000_1230, 0, 32'h200, 0, 0, 0);
        set_slot(2, 7'b000_0100, 1, 0, 32'h0040_0010, 0, 32'h204, 1, 5'h03, 1);
        inst2_bd = 1'b1;
        inst2_eret = 1'b1;
        capture();
        inst1_data_cache_addr_ok = 1;
        inst2_data_cache_addr_ok = 1;
        #2 check("pms_ex", 1, pms_ex);
        check("reflush_pc", `PMS_VEC_REFILL, reflush_pc);
        check("ex_type", 5'h03, ex_type);
        check("pms_pc", 32'h204, pms_pc);
        check("pms_bd", 1, pms_bd);
        check("pms_eret", 1, pms_eret);
        check("clear_all", 1, clear_all);
        check("inst2_valid", 0, pms_inst2_valid);
        check("valid1", 1, inst1_data_cache_valid);
        check("valid2", 0, inst2_data_cache_valid);
        @(posedge clk);
        #1 inst1_data_cache_addr_ok = 0;
        inst2_data_cache_addr_ok = 0;
        end_test();

        begin_test("backpressure");
        set_slot(1, 7'b000_0100, 0, 1, 32'h8000_0040, 32'h1111_2222, 32'h300, 0, 0, 0);
        set_slot(2, 7'b100_0000, 0, 1, 32'ha000_0043, 32'h33, 32'h304, 0, 0, 0);
        capture();
        ms_allowin = 0;
        repeat (2) begin
            #2 check("valid1 held", 0, inst1_data_cache_valid);
            check("valid2 held", 0, inst2_data_cache_valid);
            check("to_ms held", 0, pms_to_ms_valid);
            @(posedge clk);
            #1;
        end
        ms_allowin = 1;
        inst1_data_cache_addr_ok = 1;
        #2 check("valid1", 1, inst1_data_cache_valid);
        check("valid2", 1, inst2_data_cache_valid);
        check("to_ms early", 0, pms_to_ms_valid);
        @(posedge clk);
        #1 inst1_data_cache_addr_ok = 0;
        #2 check("valid1 repeated", 0, inst1_data_cache_valid);
        check("valid2 waiting", 1, inst2_data_cache_valid);
        check("to_ms early", 0, pms_to_ms_valid);
        @(posedge clk);
        #1 inst2_data_cache_addr_ok = 1;
        #2 check("valid2", 1, inst2_data_cache_valid);
        check("to_ms", 1, pms_to_ms_valid);
        @(posedge clk);
        #1 inst2_data_cache_addr_ok = 0;
        #2 check("valid2 repeated", 0, inst2_data_cache_valid);
        check("to_ms after handoff", 0, pms_to_ms_valid);
        @(posedge clk);
        #1 end_test();

        chk_fails = dut_i.chk_i.fail_count;
        $display("tests run %0d, tests failed %0d, checker failures %0d",
                 tests_run, tests_failed, chk_fails);
        if (tests_failed == 0 && chk_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
pms_mem_pkg.sv
pms_exc_pkg.sv
mem_access_decode.sv
exception_select.sv
pms_pipe_ctrl.sv
premem_stage.sv
premem_checker.sv
tb_premem_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_premem_stage -o sim_premem

# keep running past assertion errors so the testbench prints its summary
./obj_dir/sim_premem +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Regression passed" sim.log
